//--- Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP ?= procTb
OBJ_DIR ?= obj_dir
LOG ?= sim.log

SOURCES := $(shell cat list.f)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): list.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) && ! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- decode.sv
/*
 Instruction decode, control generation, immediate extension and branch resolution.
 Branches, j and jal redirect from here. jr is resolved in execute.
 halt and err are sticky and only update while the core is not frozen.
*/
module decode (
	input logic clk,
	input logic arstN,
	input procPkg::fetchBus_t fetchIn,
	input logic wbEn,
	input logic [procPkg::regAddrWidth-1:0] wbReg,
	input logic [procPkg::dataWidth-1:0] wbData,
	input logic halted,
	output procPkg::decodeBus_t decodeOut,
	output procPkg::redirect_t redirect,
	output logic halt,
	output logic err
);

	logic [procPkg::dataWidth-1:0] instr;
	procPkg::opcode_t opcode;
	procPkg::ctrl_t ctrl;
	logic [procPkg::dataWidth-1:0] read1Data;
	logic [procPkg::dataWidth-1:0] read2Data;
	logic [procPkg::dataWidth-1:0] immExt;
	logic [1:0] func;
	logic isZero;
	logic illegal;

	assign instr = fetchIn.instruction;
	assign opcode = procPkg::opcode_t'(instr[15:11]);
	assign func = instr[1:0];
	assign isZero = (read1Data == '0);

	// rs always sits in 10:8, rt or the st source in 7:5
	regFile regs0 (
		.clk(clk),
		.arstN(arstN),
		.read1Addr(instr[10:8]),
		.read2Addr(instr[7:5]),
		.writeEn(wbEn),
		.writeAddr(wbReg),
		.writeData(wbData),
		.read1Data(read1Data),
		.read2Data(read2Data)
	);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = procPkg::aluPassB;
		immExt = {{11{instr[4]}}, instr[4:0]};
		redirect.taken = 1'b0;
		illegal = 1'b0;
		case (opcode)
			procPkg::opHalt, procPkg::opNop: begin
			end
			procPkg::opAddi, procPkg::opAndi, procPkg::opLd: begin
				ctrl.aluOp = (opcode == procPkg::opAndi) ? procPkg::aluAnd : procPkg::aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = (opcode == procPkg::opLd);
				ctrl.regWrite = 1'b1;
				ctrl.writeReg = instr[7:5];
				if (opcode == procPkg::opAndi) begin
					immExt = {11'b0, instr[4:0]};
				end
			end
			procPkg::opSt: begin
				ctrl.aluOp = procPkg::aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			procPkg::opBeqz, procPkg::opBnez: begin
				immExt = {{8{instr[7]}}, instr[7:0]};
				redirect.taken = (opcode == procPkg::opBeqz) ? isZero : !isZero;
			end
			procPkg::opJ, procPkg::opJal: begin
				immExt = {{5{instr[10]}}, instr[10:0]};
				redirect.taken = 1'b1;
				ctrl.regWrite = (opcode == procPkg::opJal);
				ctrl.writeReg = procPkg::linkReg;
				ctrl.link = (opcode == procPkg::opJal);
			end
			procPkg::opJr: begin
				immExt = {{8{instr[7]}}, instr[7:0]};
				ctrl.aluOp = procPkg::aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.isJr = 1'b1;
			end
			procPkg::opRType, procPkg::opRCmp: begin
				if (opcode == procPkg::opRType) begin
					ctrl.aluOp = procPkg::aluOp_t'({1'b0, func});
				end else begin
					ctrl.aluOp = func[0] ? procPkg::aluSlt : procPkg::aluSeq;
				end
				ctrl.regWrite = 1'b1;
				ctrl.writeReg = instr[4:2];
			end
			default: illegal = 1'b1;
		endcase
		redirect.target = fetchIn.pcPlusOne + immExt[procPkg::imemAddrWidth-1:0];
	end

	assign decodeOut.ctrl = ctrl;
	assign decodeOut.read1Data = read1Data;
	assign decodeOut.read2Data = read2Data;
	assign decodeOut.immExt = immExt;
	assign decodeOut.pcPlusOne = fetchIn.pcPlusOne;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			halt <= 1'b0;
			err <= 1'b0;
		end else if (!halted) begin
			if (opcode == procPkg::opHalt) begin
				halt <= 1'b1;
			end
			err <= err | illegal;
		end
	end

	// Write-back port must stay idle while the core is frozen
	noWriteWhileHalted: assert property (@(posedge clk) disable iff (!arstN)
		halted |-> !wbEn);

endmodule

//--- execute.sv
/*
 ALU on register or immediate operands, compares and the jr target.
 seq and slt give 1 or 0, and slt compares signed. The jr target is rs plus
 the offset, truncated to the 8-bit word address.
*/
module execute (
	input procPkg::decodeBus_t decodeIn,
	output procPkg::executeBus_t executeOut,
	output procPkg::redirect_t redirect,
	output logic err
);

	logic [procPkg::dataWidth-1:0] opA;
	logic [procPkg::dataWidth-1:0] opB;
	logic [procPkg::dataWidth-1:0] aluOut;

	assign opA = decodeIn.read1Data;
	assign opB = decodeIn.ctrl.aluSrcImm ? decodeIn.immExt : decodeIn.read2Data;

	always_comb begin
		err = 1'b0;
		case (decodeIn.ctrl.aluOp)
			procPkg::aluAdd: aluOut = opA + opB;
			procPkg::aluSub: aluOut = opA - opB;
			procPkg::aluAnd: aluOut = opA & opB;
			procPkg::aluXor: aluOut = opA ^ opB;
			procPkg::aluSeq: begin
				aluOut = {{(procPkg::dataWidth-1){1'b0}}, opA == opB};
			end
			procPkg::aluSlt: begin
				aluOut = {{(procPkg::dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
			end
			procPkg::aluPassB: aluOut = opB;
			default: begin
				// Unused encoding, decode never produces it
				aluOut = '0;
				err = 1'b1;
			end
		endcase
	end

	assign executeOut.ctrl = decodeIn.ctrl;
	assign executeOut.aluOut = aluOut;
	assign executeOut.storeData = decodeIn.read2Data;
	assign executeOut.pcPlusOne = decodeIn.pcPlusOne;

	assign redirect.taken = decodeIn.ctrl.isJr;
	assign redirect.target = aluOut[procPkg::imemAddrWidth-1:0];

endmodule

//--- fetch.sv
/*
 PC, instruction memory and next-PC selection.
 While loadEn is high the PC sits at 0 and each edge writes one program word.
 The fetch error only arms once a program has been loaded.
*/
module fetch (
	input logic clk,
	input logic arstN,
	input logic loadEn,
	input logic [procPkg::imemAddrWidth-1:0] loadAddr,
	input logic [procPkg::dataWidth-1:0] loadData,
	input logic halt,
	input procPkg::redirect_t decRedirect,
	input procPkg::redirect_t exRedirect,
	output procPkg::fetchBus_t fetchOut,
	output logic err
);

	logic [procPkg::dataWidth-1:0] imem [procPkg::imemDepth];
	logic [procPkg::imemAddrWidth-1:0] pc;
	logic [procPkg::imemAddrWidth-1:0] pcPlusOne;
	logic [procPkg::imemAddrWidth-1:0] pcNext;
	// One past the highest word written by the load port
	logic [procPkg::imemAddrWidth:0] highWater;
	logic beyondLoaded;

	assign pcPlusOne = pc + 1'b1;
	assign fetchOut.instruction = imem[pc];
	assign fetchOut.pcPlusOne = pcPlusOne;

	assign beyondLoaded = !loadEn && !halt && (highWater != '0)
		&& ({1'b0, pc} >= highWater);

	// jr from execute wins over decode redirects
	always_comb begin
		if (loadEn) begin
			pcNext = '0;
		end else if (halt) begin
			pcNext = pc;
		end else if (exRedirect.taken) begin
			pcNext = exRedirect.target;
		end else if (decRedirect.taken) begin
			pcNext = decRedirect.target;
		end else begin
			pcNext = pcPlusOne;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			highWater <= '0;
			err <= 1'b0;
		end else begin
			pc <= pcNext;
			if (loadEn && ({1'b0, loadAddr} >= highWater)) begin
				highWater <= {1'b0, loadAddr} + 1'b1;
			end
			err <= err | beyondLoaded;
		end
	end

	always_ff @(posedge clk) begin
		if (loadEn) begin
			imem[loadAddr] <= loadData;
		end
	end

	redirectsExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(decRedirect.taken && exRedirect.taken));

endmodule

//--- list.f
procPkg.sv
fetch.sv
regFile.sv
decode.sv
execute.sv
memory.sv
proc.sv
procClock.sv
procTb.sv

//--- memory.sv
/*
 Data memory and write-back select. Only the low 8 address bits index the
 256-word memory; a nonzero upper byte on an access sets the sticky err.
 Nothing is written while the core is halted or loading.
*/
module memory (
	input logic clk,
	input logic arstN,
	input procPkg::executeBus_t executeIn,
	input logic halted,
	output logic wbEn,
	output logic [procPkg::regAddrWidth-1:0] wbReg,
	output logic [procPkg::dataWidth-1:0] wbData,
	output logic err
);

	logic [procPkg::dataWidth-1:0] dmem [procPkg::dmemDepth];
	logic [procPkg::dmemAddrWidth-1:0] addr;
	logic [procPkg::dataWidth-1:0] memData;
	logic writeEn;
	logic badAddr;

	assign addr = executeIn.aluOut[procPkg::dmemAddrWidth-1:0];
	assign memData = dmem[addr];
	assign writeEn = executeIn.ctrl.memWrite && !halted;
	assign badAddr = (executeIn.ctrl.memRead || executeIn.ctrl.memWrite) && !halted
		&& (executeIn.aluOut[procPkg::dataWidth-1:procPkg::dmemAddrWidth] != '0);

	assign wbEn = executeIn.ctrl.regWrite && !halted;
	assign wbReg = executeIn.ctrl.writeReg;

	// Link beats load beats ALU
	always_comb begin
		if (executeIn.ctrl.link) begin
			wbData = {{(procPkg::dataWidth-procPkg::imemAddrWidth){1'b0}},
				executeIn.pcPlusOne};
		end else if (executeIn.ctrl.memRead) begin
			wbData = memData;
		end else begin
			wbData = executeIn.aluOut;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < procPkg::dmemDepth; i++) begin
				dmem[i] <= '0;
			end
			err <= 1'b0;
		end else begin
			if (writeEn) begin
				dmem[addr] <= executeIn.storeData;
			end
			err <= err | badAddr;
		end
	end

	// One access per instruction, a load and a store never share a cycle
	memAccessExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(executeIn.ctrl.memRead && executeIn.ctrl.memWrite));

endmodule

//--- proc.sv
/*
 Single-cycle processor top: fetch, decode, execute, then memory with write-back.
 The core is frozen while halted or while loadEn is high. The trace port
 mirrors each register write during the cycle before it lands.
*/
module proc (
	input logic clk,
	input logic arstN,
	input logic loadEn,
	input logic [procPkg::imemAddrWidth-1:0] loadAddr,
	input logic [procPkg::dataWidth-1:0] loadData,
	output logic halt,
	output logic err,
	output logic wbValid,
	output logic [procPkg::regAddrWidth-1:0] wbReg,
	output logic [procPkg::dataWidth-1:0] wbData
);

	procPkg::fetchBus_t fetchBus;
	procPkg::decodeBus_t decodeBus;
	procPkg::executeBus_t executeBus;
	procPkg::redirect_t decRedirect;
	procPkg::redirect_t exRedirect;
	logic frozen;
	logic errF;
	logic errD;
	logic errX;
	logic errM;

	assign frozen = halt | loadEn;
	assign err = errF | errD | errX | errM;

	fetch fetchStage (
		.clk(clk),
		.arstN(arstN),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.halt(halt),
		.decRedirect(decRedirect),
		.exRedirect(exRedirect),
		.fetchOut(fetchBus),
		.err(errF)
	);

	decode decodeStage (
		.clk(clk),
		.arstN(arstN),
		.fetchIn(fetchBus),
		.wbEn(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(frozen),
		.decodeOut(decodeBus),
		.redirect(decRedirect),
		.halt(halt),
		.err(errD)
	);

	execute executeStage (
		.decodeIn(decodeBus),
		.executeOut(executeBus),
		.redirect(exRedirect),
		.err(errX)
	);

	memory memoryStage (
		.clk(clk),
		.arstN(arstN),
		.executeIn(executeBus),
		.halted(frozen),
		.wbEn(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.err(errM)
	);

endmodule

//--- procClock.sv
/*
 Testbench clock and reset source with a 10 ns period.
 arstN is low from time zero and again after any resetReq, for 3 rising edges.
*/
module procClock (
	input logic resetReq,
	output logic clk,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [1:0] lowCycles = '0;

	assign arstN = (lowCycles == 2'd3);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (resetReq) begin
			lowCycles <= '0;
		end else if (lowCycles != 2'd3) begin
			lowCycles <= lowCycles + 2'd1;
		end
	end

endmodule

//--- procPkg.sv
/*
 Shared sizes, encodings and stage buses for the single-cycle 16-bit processor.
 Opcode and ALU values are fixed here, and programs and models depend on them.
 The PC and all jump targets are 8-bit word addresses. jal always links into r7.
*/
package procPkg;

	localparam int dataWidth = 16;
	localparam int regAddrWidth = 3;
	localparam int imemDepth = 256;
	localparam int imemAddrWidth = 8;
	localparam int dmemDepth = 256;
	localparam int dmemAddrWidth = 8;

	// Link register written by jal
	localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

	// Instruction bits 15 to 11
	typedef enum logic [4:0] {
		opHalt = 5'd0,
		opNop = 5'd1,
		opAddi = 5'd2,
		opAndi = 5'd3,
		opLd = 5'd4,
		opSt = 5'd5,
		opBeqz = 5'd6,
		opBnez = 5'd7,
		opJ = 5'd8,
		opJal = 5'd9,
		opJr = 5'd10,
		opRType = 5'd11,
		opRCmp = 5'd12
	} opcode_t;

	// First four values line up with the R-type function field
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluXor = 3'd3,
		aluSeq = 3'd4,
		aluSlt = 3'd5,
		aluPassB = 3'd6
	} aluOp_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic aluSrcImm;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic [regAddrWidth-1:0] writeReg;
		logic link;
		logic isJr;
	} ctrl_t;

	typedef struct packed {
		logic [dataWidth-1:0] instruction;
		logic [imemAddrWidth-1:0] pcPlusOne;
	} fetchBus_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [dataWidth-1:0] read1Data;
		logic [dataWidth-1:0] read2Data;
		logic [dataWidth-1:0] immExt;
		logic [imemAddrWidth-1:0] pcPlusOne;
	} decodeBus_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [dataWidth-1:0] aluOut;
		logic [dataWidth-1:0] storeData;
		logic [imemAddrWidth-1:0] pcPlusOne;
	} executeBus_t;

	typedef struct packed {
		logic taken;
		logic [imemAddrWidth-1:0] target;
	} redirect_t;

endpackage

//--- procTb.sv
/*
 Directed testbench for the single-cycle processor. Each test builds a program,
 loads it under a fresh reset and compares the write-back trace with a model of
 the instruction set. Trace outputs are sampled on the falling edge.
 loadEn stays high through reset, so the core never runs stale memory.
*/
module procTb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic arstN;
	logic resetReq;
	logic loadEn;
	logic [procPkg::imemAddrWidth-1:0] loadAddr;
	logic [procPkg::dataWidth-1:0] loadData;
	logic halt;
	logic err;
	logic wbValid;
	logic [procPkg::regAddrWidth-1:0] wbReg;
	logic [procPkg::dataWidth-1:0] wbData;

	logic [15:0] progWords[$];
	// Trace entries are {register, value}
	logic [18:0] observed[$];
	logic [18:0] expected[$];
	string testName;
	int errors = 0;
	logic [31:0] lcgState = 32'd73928;

	procClock clkGen0 (
		.resetReq(resetReq),
		.clk(clk),
		.arstN(arstN)
	);

	proc dut0 (
		.clk(clk),
		.arstN(arstN),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.halt(halt),
		.err(err),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	function automatic logic [4:0] randImm();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[20:16];
	endfunction

	function automatic logic [15:0] encR(logic [4:0] op, logic [2:0] rs, logic [2:0] rt,
		logic [2:0] rd, logic [1:0] fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] encI(logic [4:0] op, logic [2:0] rs, logic [2:0] rd,
		logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] encB(logic [4:0] op, logic [2:0] rs, logic [7:0] off);
		return {op, rs, off};
	endfunction

	function automatic logic [15:0] encJ(logic [4:0] op, logic [10:0] off);
		return {op, off};
	endfunction

	task automatic loadProgram();
		int waitCycles;
		@(posedge clk);
		resetReq <= 1'b1;
		loadEn <= 1'b1;
		loadAddr <= '0;
		loadData <= '0;
		@(posedge clk);
		resetReq <= 1'b0;
		// arstN falls on the edge that sees the request
		@(posedge clk);
		waitCycles = 0;
		while (!arstN && waitCycles < 10) begin
			@(posedge clk);
			waitCycles++;
		end
		assert (arstN) else begin
			errors++;
			$display("%s: reset did not release within 10 cycles", testName);
		end
		foreach (progWords[i]) begin
			loadAddr <= 8'(i);
			loadData <= progWords[i];
			@(posedge clk);
		end
		loadEn <= 1'b0;
	endtask

	task automatic runUntilHalt();
		int cycles;
		observed.delete();
		cycles = 0;
		while (!halt && cycles < 200) begin
			@(negedge clk);
			if (wbValid) begin
				observed.push_back({wbReg, wbData});
			end
			cycles++;
		end
		assert (halt) else begin
			errors++;
			$display("%s: halt not reached within 200 cycles", testName);
		end
	endtask

	// Instruction set model, written from the encoding rules
	task automatic modelProgram();
		logic [15:0] mRegs [8];
		logic [15:0] mMem [256];
		logic [7:0] pc;
		logic [7:0] nextPc;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] addr;
		logic [2:0] wrReg;
		logic [15:0] wrVal;
		logic wr;
		logic done;
		int steps;
		foreach (mRegs[i]) begin
			mRegs[i] = '0;
		end
		foreach (mMem[i]) begin
			mMem[i] = '0;
		end
		expected.delete();
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 200 && int'(pc) < progWords.size()) begin
			ins = progWords[pc];
			a = mRegs[ins[10:8]];
			b = mRegs[ins[7:5]];
			addr = a + {{11{ins[4]}}, ins[4:0]};
			nextPc = pc + 8'd1;
			wr = 1'b0;
			wrReg = ins[7:5];
			wrVal = '0;
			case (ins[15:11])
				procPkg::opHalt: done = 1'b1;
				procPkg::opAddi: begin
					wr = 1'b1;
					wrVal = addr;
				end
				procPkg::opAndi: begin
					wr = 1'b1;
					wrVal = a & {11'b0, ins[4:0]};
				end
				procPkg::opLd: begin
					wr = 1'b1;
					wrVal = mMem[addr[7:0]];
				end
				procPkg::opSt: mMem[addr[7:0]] = b;
				procPkg::opBeqz: if (a == '0) nextPc = pc + 8'd1 + ins[7:0];
				procPkg::opBnez: if (a != '0) nextPc = pc + 8'd1 + ins[7:0];
				procPkg::opJ: nextPc = pc + 8'd1 + ins[7:0];
				procPkg::opJal: begin
					wr = 1'b1;
					wrReg = procPkg::linkReg;
					wrVal = {8'b0, pc + 8'd1};
					nextPc = pc + 8'd1 + ins[7:0];
				end
				procPkg::opJr: nextPc = a[7:0] + ins[7:0];
				procPkg::opRType: begin
					wr = 1'b1;
					wrReg = ins[4:2];
					case (ins[1:0])
						2'd0: wrVal = a + b;
						2'd1: wrVal = a - b;
						2'd2: wrVal = a & b;
						default: wrVal = a ^ b;
					endcase
				end
				procPkg::opRCmp: begin
					wr = 1'b1;
					wrReg = ins[4:2];
					wrVal = ins[0] ? {15'b0, $signed(a) < $signed(b)} : {15'b0, a == b};
				end
				// Illegal codes write nothing
				default: ;
			endcase
			if (wr) begin
				mRegs[wrReg] = wrVal;
				expected.push_back({wrReg, wrVal});
			end
			pc = nextPc;
			steps++;
		end
	endtask

	task automatic compareTrace();
		assert (observed.size() == expected.size()) else begin
			errors++;
			$display("FAIL %s trace length expected %0d actual %0d", testName,
				expected.size(), observed.size());
		end
		foreach (expected[i]) begin
			if (i < observed.size()) begin
				assert (observed[i] == expected[i]) else begin
					errors++;
					$display("FAIL %s write %0d expected r%0d=%h actual r%0d=%h", testName, i,
						expected[i][18:16], expected[i][15:0], observed[i][18:16],
						observed[i][15:0]);
				end
			end
		end
	endtask

	task automatic runTest(input logic expectErr);
		loadProgram();
		runUntilHalt();
		modelProgram();
		compareTrace();
		assert (err == expectErr) else begin
			errors++;
			$display("FAIL %s err expected %0b actual %0b", testName, expectErr, err);
		end
	endtask

	task automatic testAlu();
		logic [4:0] immA;
		logic [4:0] immB;
		testName = "testAlu";
		for (int round = 0; round < 3; round++) begin
			immA = randImm();
			immB = randImm();
			// Last round forces equal operands so seq gives 1
			if (round == 2) begin
				immB = immA;
			end
			progWords = '{encI(procPkg::opAddi, 0, 1, immA), encI(procPkg::opAddi, 0, 2, immB),
				encI(procPkg::opAndi, 1, 3, randImm()), encR(procPkg::opRType, 1, 2, 4, 0),
				encR(procPkg::opRType, 1, 2, 5, 1), encR(procPkg::opRType, 1, 2, 6, 2),
				encR(procPkg::opRType, 1, 2, 7, 3), encR(procPkg::opRCmp, 1, 2, 4, 0),
				encR(procPkg::opRCmp, 1, 2, 5, 1), encR(procPkg::opRCmp, 2, 1, 6, 1),
				encJ(procPkg::opHalt, 0)};
			runTest(1'b0);
		end
	endtask

	task automatic testMemory();
		testName = "testMemory";
		progWords = '{encI(procPkg::opAddi, 0, 1, 5), encI(procPkg::opAddi, 0, 2, randImm()),
			encI(procPkg::opAddi, 0, 3, 7), encI(procPkg::opSt, 0, 1, 4),
			encI(procPkg::opSt, 3, 2, 2), encI(procPkg::opSt, 1, 3, 15),
			encI(procPkg::opLd, 0, 4, 4), encI(procPkg::opLd, 3, 5, 2),
			encI(procPkg::opLd, 1, 6, 15), encJ(procPkg::opHalt, 0)};
		runTest(1'b0);
	endtask

	task automatic testBranch();
		testName = "testBranch";
		progWords = '{encI(procPkg::opAddi, 0, 1, 0), encB(procPkg::opBeqz, 1, 1),
			encI(procPkg::opAddi, 0, 2, 9), encB(procPkg::opBnez, 1, 1),
			encI(procPkg::opAddi, 0, 3, 3), encI(procPkg::opAddi, 0, 4, 1),
			encB(procPkg::opBnez, 4, 1), encI(procPkg::opAddi, 0, 5, 5),
			encB(procPkg::opBeqz, 4, 1), encI(procPkg::opAddi, 0, 6, 6),
			encJ(procPkg::opHalt, 0)};
		runTest(1'b0);
		// r2 and r5 sit behind taken branches
		foreach (observed[i]) begin
			assert (observed[i][18:16] != 3'd2 && observed[i][18:16] != 3'd5) else begin
				errors++;
				$display("%s: skipped instruction wrote r%0d", testName, observed[i][18:16]);
			end
		end
	endtask

	task automatic testJump();
		logic linked;
		testName = "testJump";
		progWords = '{encJ(procPkg::opJ, 1), encI(procPkg::opAddi, 0, 1, 1),
			encJ(procPkg::opJal, 1), encI(procPkg::opAddi, 0, 2, 2),
			encI(procPkg::opAddi, 0, 3, 8), encB(procPkg::opJr, 3, 1),
			encI(procPkg::opAddi, 0, 4, 4), encI(procPkg::opAddi, 0, 4, 4),
			encI(procPkg::opAddi, 0, 4, 4), encI(procPkg::opAddi, 0, 5, 5),
			encJ(procPkg::opHalt, 0)};
		runTest(1'b0);
		linked = 1'b0;
		foreach (observed[i]) begin
			if (observed[i] == {procPkg::linkReg, 16'd3}) begin
				linked = 1'b1;
			end
		end
		assert (linked) else begin
			errors++;
			$display("FAIL %s link expected r7=0003 actual no such write", testName);
		end
	endtask

	task automatic testHalt();
		testName = "testHalt";
		progWords = '{encI(procPkg::opAddi, 0, 1, 3), encJ(procPkg::opHalt, 0),
			encI(procPkg::opAddi, 0, 2, 4)};
		runTest(1'b0);
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			assert (halt && !wbValid) else begin
				errors++;
				$display("%s: core left halt or wrote r%0d after halt", testName, wbReg);
			end
		end
	endtask

	task automatic testIllegal();
		testName = "testIllegal";
		progWords = '{encI(procPkg::opAddi, 0, 1, 1), 16'hF800,
			encI(procPkg::opAddi, 0, 2, 2), encJ(procPkg::opHalt, 0)};
		runTest(1'b1);
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			assert (err) else begin
				errors++;
				$display("%s: err dropped without a reset", testName);
			end
		end
	endtask

	initial begin
		resetReq = 1'b0;
		loadEn = 1'b1;
		loadAddr = '0;
		loadData = '0;
		testAlu();
		testMemory();
		testBranch();
		testJump();
		testHalt();
		testIllegal();
		$display("Closing report: %0d errors", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- regFile.sv
/*
 Eight 16-bit registers, two asynchronous read ports, one clocked write port.
 A read in the write cycle returns the old value. Reset clears every register.
*/
module regFile (
	input logic clk,
	input logic arstN,
	input logic [procPkg::regAddrWidth-1:0] read1Addr,
	input logic [procPkg::regAddrWidth-1:0] read2Addr,
	input logic writeEn,
	input logic [procPkg::regAddrWidth-1:0] writeAddr,
	input logic [procPkg::dataWidth-1:0] writeData,
	output logic [procPkg::dataWidth-1:0] read1Data,
	output logic [procPkg::dataWidth-1:0] read2Data
);

	logic [procPkg::dataWidth-1:0] regs [2**procPkg::regAddrWidth];

	assign read1Data = regs[read1Addr];
	assign read2Data = regs[read2Addr];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**procPkg::regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule
